// File: Bender.yml
package:
  name: i2s_rx

sources:
  - src/i2s_rx_pkg.sv
  - src/i2s_rx_sync.sv
  - src/i2s_rx_deserializer.sv
  - src/i2s_rx_frame_fifo.sv
  - src/i2s_rx_top.sv
  - target: test
    files:
      - test/i2s_rx_tb.sv

// File: i2s_rx.f
src/i2s_rx_pkg.sv
src/i2s_rx_sync.sv
src/i2s_rx_deserializer.sv
src/i2s_rx_frame_fifo.sv
src/i2s_rx_top.sv
test/i2s_rx_tb.sv

// File: src/i2s_rx_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

// Turns the synchronized I2S bit stream into left and right samples.
// Arms on reset release or on a rising enable, starts on the next
// word select fall and strobes xfc once per stereo frame.

module i2s_rx_deserializer (
    input  wire logic                      clk,        // System clock
    input  wire logic                      rst_n,      // Async reset, active low
    input  wire i2s_rx_pkg::serial_pins_t  pins,       // Strobe and samples from sync
    input  wire logic                      en,         // Receiver enable level
    output i2s_rx_pkg::stereo_frame_t      frame_out,  // Last completed frame
    output logic                           xfc         // Transfer complete strobe
);

    import i2s_rx_pkg::*;

    logic [1:0]          rst_q;          // Shifts in ones after reset release
    logic                en_d;           // Previous enable for edge detect
    logic                ws_d;           // Word select at the previous sck rise
    logic                arm_trig;       // Reset release or en rise
    logic                ws_fall;        // Word select 1 to 0 seen with an sck rise
    logic                armed1;         // Waiting for the first ws fall
    logic                armed2;         // ws fall seen, waiting for next sck rise
    logic                active;         // Shifting data
    logic                in_left;        // Current channel, 1 for left
    logic                in_left_d;      // in_left one clk back
    logic                pre_xfc;        // Right to left change, before register
    logic [SAMPLE_W-1:0] left_sr;        // Left channel shift register
    logic [SAMPLE_W-1:0] right_sr;       // Right channel shift register

    ////////////////////////////////////////
    // Arming
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rst_q <= 2'b00;
            en_d  <= 1'b0;
        end
        else
        begin
            rst_q <= {rst_q[0], 1'b1};
            en_d  <= en;
        end
    end

    // First clk after reset release, or a rising enable
    assign arm_trig = (rst_q == 2'b01) || (en && !en_d);

    // Word select tracked at every serial clock rise
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ws_d <= 1'b0;
        else if (pins.sck_rise)
            ws_d <= pins.ws;
    end

    assign ws_fall = pins.sck_rise && ws_d && !pins.ws;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            armed1 <= 1'b0;
        else if (arm_trig)
            armed1 <= 1'b1;
        else if (ws_fall)
            armed1 <= 1'b0;                 // Fall consumed by armed2
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            armed2 <= 1'b0;
        else if (armed1 && ws_fall)
            armed2 <= 1'b1;
        else if (pins.sck_rise)
            armed2 <= 1'b0;                 // Next rise hands over to active
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            active <= 1'b0;
        else if (!en)
            active <= 1'b0;                 // Enable low wins
        else if (armed2 && pins.sck_rise)
            active <= 1'b1;
    end

    ////////////////////////////////////////
    // Channel tracking and transfer complete
    ////////////////////////////////////////

    // Channel follows ws one bit late, the standard I2S delay
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            in_left <= 1'b1;
        else if (active && pins.sck_rise)
            in_left <= !pins.ws;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            in_left_d <= 1'b1;
        else
            in_left_d <= in_left;
    end

    // Right channel just finished
    assign pre_xfc = in_left && !in_left_d;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            xfc <= 1'b0;
        else
            xfc <= pre_xfc;
    end

    ////////////////////////////////////////
    // Shift registers, MSB first
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            left_sr  <= '0;
            right_sr <= '0;
        end
        else if (active && pins.sck_rise)
        begin
            if (in_left)
                left_sr  <= {left_sr[SAMPLE_W-2:0], pins.sd};
            else
                right_sr <= {right_sr[SAMPLE_W-2:0], pins.sd};
        end
    end

    // Left is untouched until the next sck rise, well after xfc
    assign frame_out.left  = left_sr;
    assign frame_out.right = right_sr;

endmodule

`default_nettype wire

// File: src/i2s_rx_frame_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// Show-ahead FIFO of stereo frames.
// rdata always shows the oldest frame, rd pops it.

module i2s_rx_frame_fifo (
    input  wire logic                             clk,       // System clock
    input  wire logic                             rst_n,     // Async reset, active low
    input  wire logic                             wr,        // Write strobe
    input  wire i2s_rx_pkg::stereo_frame_t        wdata,     // Frame to store
    input  wire logic                             rd,        // Read strobe
    output i2s_rx_pkg::stereo_frame_t             rdata,     // Oldest frame
    output logic                                  empty,     // No frame held
    output logic                                  full,      // FIFO_DEPTH frames held
    output logic                                  overflow,  // Write dropped, sticky
    output logic [i2s_rx_pkg::CNT_W-1:0]          count      // Frames held
);

    import i2s_rx_pkg::*;

    stereo_frame_t    mem [FIFO_DEPTH];     // Frame storage
    logic [PTR_W-1:0] wr_ptr;               // Next slot to write
    logic [PTR_W-1:0] rd_ptr;               // Slot shown on rdata
    logic [PTR_W-1:0] rd_ptr_nxt;           // Slot after the read slot
    logic             do_rd;                // Pop accepted
    logic             do_wr;                // Write accepted

    ////////////////////////////////////////
    // Flags and accept logic
    ////////////////////////////////////////

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));

    assign do_rd = rd && !empty;            // Read while empty is ignored
    assign do_wr = wr && (!full || do_rd);  // Full but popping frees a slot

    assign rd_ptr_nxt = rd_ptr + 1'b1;      // Wraps, depth is a power of two

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wdata;
    end

    ////////////////////////////////////////
    // Pointers, count, overflow
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr_nxt;

            // Write and read together leave count alone
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;

            if (wr && !do_wr)
                overflow <= 1'b1;           // Held until reset
        end
    end

    ////////////////////////////////////////
    // Show-ahead output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else if (do_rd)
        begin
            if (count > CNT_W'(1))
                rdata <= mem[rd_ptr_nxt];   // Next stored frame
            else if (do_wr)
                rdata <= wdata;             // Bypass, last frame leaving
        end
        else if (empty && do_wr)
        begin
            rdata <= wdata;                 // First frame into an empty FIFO
        end
    end

endmodule

`default_nettype wire

// File: src/i2s_rx_pkg.sv
`default_nettype none

// Shared sizes and bus types for the I2S receiver

package i2s_rx_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int SAMPLE_W    = 16;                  // Bits per channel sample
    localparam int FIFO_DEPTH  = 8;                   // Stereo frames held in the FIFO
    localparam int CNT_W       = 4;                   // Fill count holds 0 to FIFO_DEPTH
    localparam int PTR_W       = $clog2(FIFO_DEPTH);  // FIFO slot index
    localparam int SYNC_STAGES = 2;                   // Flops per synchronizer chain

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Pin samples handed from the synchronizer to the deserializer
    typedef struct packed {
        logic sck_rise;                               // One clk per serial clock rise
        logic ws;                                     // Word select at that rise
        logic sd;                                     // Serial data at that rise
    } serial_pins_t;

    // One complete stereo sample pair
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } stereo_frame_t;

endpackage

`default_nettype wire

// File: src/i2s_rx_sync.sv
`timescale 1ns/10ps
`default_nettype none

// Brings the slow I2S pins into the clk domain and marks serial clock rises

module i2s_rx_sync (
    input  wire logic                     clk,    // System clock
    input  wire logic                     rst_n,  // Async reset, active low
    input  wire logic                     sck,    // I2S serial clock pin
    input  wire logic                     ws,     // I2S word select pin
    input  wire logic                     sd,     // I2S serial data pin
    output i2s_rx_pkg::serial_pins_t      pins    // Edge strobe with aligned samples
);

    import i2s_rx_pkg::*;

    ////////////////////////////////////////
    // Synchronizer chains
    ////////////////////////////////////////

    // One 3-bit word per stage, bit 2 sck, bit 1 ws, bit 0 sd
    logic [SYNC_STAGES-1:0][2:0] chain;
    logic                        sck_s;    // Synchronized serial clock
    logic                        ws_s;     // Synchronized word select
    logic                        sd_s;     // Synchronized serial data
    logic                        sck_d;    // Previous sck_s for edge detect

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            chain <= '0;
        end
        else
        begin
            chain[0] <= {sck, ws, sd};         // First stage takes the raw pins
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                chain[i] <= chain[i-1];
            end
        end
    end

    // Last stage of each chain
    assign sck_s = chain[SYNC_STAGES-1][2];
    assign ws_s  = chain[SYNC_STAGES-1][1];
    assign sd_s  = chain[SYNC_STAGES-1][0];

    ////////////////////////////////////////
    // Edge detect and output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_d <= 1'b0;
            pins  <= '0;
        end
        else
        begin
            sck_d         <= sck_s;
            pins.sck_rise <= sck_s & ~sck_d;   // 0 to 1 step, one clk wide
            pins.ws       <= ws_s;             // Same stage as the edge
            pins.sd       <= sd_s;
        end
    end

endmodule

`default_nettype wire

// File: src/i2s_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

// I2S receiver top.
// Pins go through the synchronizer into the deserializer,
// completed frames are queued in the frame FIFO.

module i2s_rx_top (
    input  wire logic                     clk,       // System clock
    input  wire logic                     rst_n,     // Async reset, active low
    input  wire logic                     sck,       // I2S serial clock
    input  wire logic                     ws,        // I2S word select
    input  wire logic                     sd,        // I2S serial data
    input  wire logic                     en,        // Receiver enable
    input  wire logic                     rd,        // Pop the shown frame
    output i2s_rx_pkg::stereo_frame_t     frame,     // Oldest queued frame
    output logic                          empty,     // FIFO empty
    output logic                          full,      // FIFO full
    output logic                          overflow,  // Frame dropped, sticky
    output logic [i2s_rx_pkg::CNT_W-1:0]  count      // Frames queued
);

    import i2s_rx_pkg::*;

    serial_pins_t  pins;       // Synchronized pins with edge strobe
    stereo_frame_t rx_frame;   // Deserializer output
    logic          xfc;        // Frame complete, writes the FIFO

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    i2s_rx_sync u_sync (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd),
        .pins  (pins)
    );

    ////////////////////////////////////////
    // Deserializer
    ////////////////////////////////////////

    i2s_rx_deserializer u_deser (
        .clk       (clk),
        .rst_n     (rst_n),
        .pins      (pins),
        .en        (en),
        .frame_out (rx_frame),
        .xfc       (xfc)
    );

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    i2s_rx_frame_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (xfc),          // No back-pressure on the stream
        .wdata    (rx_frame),
        .rd       (rd),
        .rdata    (frame),
        .empty    (empty),
        .full     (full),
        .overflow (overflow),
        .count    (count)
    );

endmodule

`default_nettype wire

// File: test/i2s_rx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2s_rx_tb;

    import i2s_rx_pkg::*;

    localparam int N_FRAMES       = 12;     // 8 fixed and 4 random table entries
    localparam int FRAMES_SENT    = 34;     // 14 capture, 11 buffering, 9 enable
    localparam int TIMEOUT_CYCLES = FRAMES_SENT * 256 * 5 / 2;
    localparam int ARRIVE_WAIT    = 64;     // clk cycles from last bit to frame shown

    logic             clk;
    logic             rst_n;
    logic             sck;
    logic             ws;
    logic             sd;
    logic             en;
    logic             rd;
    stereo_frame_t    frame;
    logic             empty;
    logic             full;
    logic             overflow;
    logic [CNT_W-1:0] count;

    stereo_frame_t    frame_tbl [N_FRAMES];   // Sent frames, read back unchanged
    int               n_pass;
    int               n_fail;
    int               test_fails;             // n_fail when the test began
    int               cycles;                 // Watchdog counter

    i2s_rx_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .en       (en),
        .rd       (rd),
        .frame    (frame),
        .empty    (empty),
        .full     (full),
        .overflow (overflow),
        .count    (count)
    );

    always #10 clk = ~clk;                    // 20 ns period

    // Watchdog sized from the frames sent
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
            n_fail++;
        end
        else
            n_pass++;
    endtask

    // I2S transmitter with 32 sck periods of 8 clk
    task automatic send_frame(input stereo_frame_t f);
        logic [31:0] bits;
        bits = f;                               // Left MSB first followed by right
        for (int k = 0; k < 32; k++)
        begin
            @(posedge clk);
            sck <= 1'b0;                        // Falling edge where ws and sd change
            sd  <= bits[31-k];
            ws  <= (k >= 15) && (k <= 30);      // One bit ahead of the channel
            repeat (4) @(posedge clk);
            sck <= 1'b1;                        // Receiver samples on this rise
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic wait_frame(input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (empty && n < ARRIVE_WAIT)
        begin
            @(negedge clk);
            n++;
        end
        if (empty)
        begin
            $display("Error at %0d ns: frame %0d never reached the FIFO", $time, idx);
            n_fail++;
        end
    endtask

    task automatic pop_frame(output stereo_frame_t f);
        @(negedge clk);
        f = frame;                              // Show-ahead so already valid
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;                             // Pop happens on this edge
        @(negedge clk);
    endtask

    // Pops one frame and compares it with table entry idx
    task automatic check_popped(input int idx);
        stereo_frame_t got;
        if (empty)
        begin
            $display("Error at %0d ns: FIFO empty, frame %0d missing", $time, idx);
            n_fail++;
        end
        else
        begin
            pop_frame(got);
            compare($sformatf("frame %0d left", idx), got.left, frame_tbl[idx].left);
            compare($sformatf("frame %0d right", idx), got.right, frame_tbl[idx].right);
        end
    endtask

    // Throws away whatever the lead-in left behind
    task automatic drain_fifo();
        stereo_frame_t junk;
        repeat (16) @(negedge clk);             // Last xfc lands well inside this
        while (!empty)
            pop_frame(junk);
    endtask

    task automatic report_test(input string name);
        if (n_fail == test_fails)
            $display("Test %-10s ok", name);
        else
            $display("Test %-10s %0d error(s)", name, n_fail - test_fails);
        test_fails = n_fail;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int rnd_seed;

        clk        = 1'b0;
        rst_n      = 1'b0;
        sck        = 1'b0;
        ws         = 1'b0;                      // Left channel with no ws fall before slot 31
        sd         = 1'b0;
        en         = 1'b1;
        rd         = 1'b0;
        n_pass     = 0;
        n_fail     = 0;
        test_fails = 0;
        cycles     = 0;
        rnd_seed   = 32'hd92c;

        frame_tbl[0] = {16'h8001, 16'h7fff};
        frame_tbl[1] = {16'ha5a5, 16'h5a5a};
        frame_tbl[2] = {16'hffff, 16'h0000};
        frame_tbl[3] = {16'h0000, 16'hffff};
        frame_tbl[4] = {16'h1234, 16'habcd};
        frame_tbl[5] = {16'h8000, 16'h0001};
        frame_tbl[6] = {16'hfedc, 16'hba98};
        frame_tbl[7] = {16'h7fff, 16'h8001};
        frame_tbl[8] = $urandom(rnd_seed);      // First draw seeds the generator
        for (int i = 9; i < N_FRAMES; i++)
            frame_tbl[i] = $urandom;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;                          // Release arms the receiver

        // Reset values
        repeat (4) @(negedge clk);
        compare("empty after reset", empty, 1'b1);
        compare("full after reset", full, 1'b0);
        compare("count after reset", count, 0);
        compare("overflow after reset", overflow, 1'b0);
        compare("frame after reset", frame, 0);
        report_test("reset");

        // Read strobe with nothing stored
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
        @(negedge clk);
        compare("count after empty read", count, 0);
        compare("empty after empty read", empty, 1'b1);
        compare("overflow after empty read", overflow, 1'b0);
        report_test("empty_read");

        // Capture with frames popped as they arrive
        send_frame('0);                         // Holds the arming ws fall
        send_frame('0);                         // Lead-in that may be partial
        drain_fifo();
        for (int i = 0; i < N_FRAMES; i++)
        begin
            send_frame(frame_tbl[i]);
            wait_frame(i);
            compare($sformatf("count with frame %0d waiting", i), count, 1);
            check_popped(i);
        end
        report_test("capture");

        // Buffering ten frames into eight slots
        send_frame('0);
        drain_fifo();
        for (int i = 0; i < 10; i++)
            send_frame(frame_tbl[i]);
        repeat (16) @(negedge clk);
        compare("count when full", count, FIFO_DEPTH);
        compare("full", full, 1'b1);
        compare("overflow after drops", overflow, 1'b1);
        for (int i = 0; i < FIFO_DEPTH; i++)
            check_popped(i);                    // First eight survive
        compare("empty after eight pops", empty, 1'b1);
        report_test("buffering");

        // Enable dropped mid stream
        fork
            send_frame(frame_tbl[0]);
            begin
                repeat (100) @(posedge clk);
                en <= 1'b0;                     // Inside the left channel
            end
        join
        send_frame(frame_tbl[1]);
        send_frame(frame_tbl[2]);
        repeat (16) @(negedge clk);
        compare("count while disabled", count, 0);
        @(posedge clk);
        en <= 1'b1;                             // Re-arm
        send_frame('0);                         // Re-arming ws fall
        send_frame('0);                         // Lead-in
        drain_fifo();
        for (int i = 8; i < N_FRAMES; i++)
        begin
            send_frame(frame_tbl[i]);
            wait_frame(i);
            check_popped(i);
        end
        report_test("enable");

        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
